//--- rtl/decodeStage.sv
`default_nettype none

module decodeStage
    import mipsPkg::*;
(
    input fetchPair_t fetchIn,
    output logic [3:0][4:0] regAddr,
    input logic [3:0][31:0] regData,
    output execPair_t execOut
);

    function automatic execSlot_t decodeSlot(
        input fetchSlot_t f,
        input logic [31:0] rsVal,
        input logic [31:0] rtVal
    );
        execSlot_t s;
        logic [5:0] opcode;
        logic [5:0] funct;
        opcode = f.instr[31:26];
        funct = f.instr[5:0];
        s = '0;
        s.valid = f.valid;
        s.op = aluNop;
        s.rs = f.instr[25:21];
        s.rt = f.instr[20:16];
        s.valA = rsVal;
        s.valB = rtVal;
        s.pc = f.pc;
        s.imm = {{16{f.instr[15]}}, f.instr[15:0]};
        case (opcode)
            opSpecial:
            begin
                s.dest = f.instr[15:11];
                s.writes = 1'b1;
                case (funct)
                    fnAddu: s.op = aluAdd;
                    fnSubu: s.op = aluSub;
                    fnAnd: s.op = aluAnd;
                    fnOr: s.op = aluOr;
                    fnXor: s.op = aluXor;
                    fnSlt: s.op = aluSlt;
                    default: s.writes = 1'b0; // includes sll 0, the nop.
                endcase
            end
            opSpecial2:
            begin
                s.dest = f.instr[15:11];
                s.writes = (funct == fnMul);
                s.op = (funct == fnMul) ? aluMul : aluNop;
            end
            opAddiu:
            begin
                s.op = aluAdd;
                s.dest = s.rt;
                s.writes = 1'b1;
                s.useImm = 1'b1;
            end
            opOri:
            begin
                s.op = aluOr;
                s.dest = s.rt;
                s.writes = 1'b1;
                s.useImm = 1'b1;
                s.imm = {16'd0, f.instr[15:0]}; // zero extended.
            end
            opLui:
            begin
                s.op = aluLui;
                s.dest = s.rt;
                s.writes = 1'b1;
                s.useImm = 1'b1;
                s.imm = {f.instr[15:0], 16'd0};
            end
            opBeq: s.op = aluBeq;
            opBne: s.op = aluBne;
            default: s.op = aluNop;
        endcase
        // writes to $zero are dropped here.
        s.writes = s.writes && (s.dest != 5'd0);
        return s;
    endfunction

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            regAddr[2 * i] = fetchIn[i].instr[25:21];
            regAddr[2 * i + 1] = fetchIn[i].instr[20:16];
            execOut[i] = decodeSlot(fetchIn[i], regData[2 * i], regData[2 * i + 1]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/dualIssueCore.sv
`default_nettype none

module dualIssueCore
    import mipsPkg::*;
(
    input logic clk,
    input logic reset,
    input logic imemReady,
    input logic [1:0][31:0] imemData,
    output logic [31:0] imemAddr,
    output commitPair_t commit
);

    fetchPair_t fetched, decodeIn;
    execPair_t decoded, execIn;
    logic [3:0][4:0] regAddr;
    logic [3:0][31:0] regData;
    logic busy;
    logic redirect;
    logic [31:0] redirectPc;
    logic firstCycle;

    fetchStage fetch (
        .clk(clk),
        .reset(reset),
        .stall(busy),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .imemReady(imemReady),
        .imemData(imemData),
        .imemAddr(imemAddr),
        .fetchOut(fetched)
    );

    pipeReg #(.payloadType(fetchPair_t)) decodeReg (
        .clk(clk),
        .reset(reset),
        .stall(busy),
        .flush(redirect),
        .din(fetched),
        .dout(decodeIn),
        .firstCycle() // decode is single cycle.
    );

    decodeStage decode (
        .fetchIn(decodeIn),
        .regAddr(regAddr),
        .regData(regData),
        .execOut(decoded)
    );

    regFile regs (
        .clk(clk),
        .readAddr(regAddr),
        .readData(regData),
        .writes(commit)
    );

    pipeReg #(.payloadType(execPair_t)) execReg (
        .clk(clk),
        .reset(reset),
        .stall(busy),
        .flush(redirect),
        .din(decoded),
        .dout(execIn),
        .firstCycle(firstCycle)
    );

    executeStage execute (
        .clk(clk),
        .reset(reset),
        .execIn(execIn),
        .firstCycle(firstCycle),
        .busy(busy),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .commit(commit)
    );

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`default_nettype none

module executeStage
    import mipsPkg::*;
(
    input logic clk,
    input logic reset,
    input execPair_t execIn,
    input logic firstCycle,
    output logic busy,
    output logic redirect,
    output logic [31:0] redirectPc,
    output commitPair_t commit
);

    logic [1:0][31:0] fwdA, fwdB;
    logic [1:0][31:0] savedA, savedB;
    logic [1:0][31:0] opA, opB;
    logic [1:0][31:0] result;
    logic [1:0][31:0] target;
    logic [1:0] taken;
    logic hasMul;
    logic [mulCountWidth-1:0] mulCount, cyclesDone;
    commitPair_t commitNext;

    // newest writeback value wins.
    function automatic logic [31:0] forward(
        input logic [4:0] r,
        input logic [31:0] v,
        input commitPair_t c
    );
        logic [31:0] res;
        res = v;
        if (c[0].valid && c[0].dest == r)
            res = c[0].value;
        if (c[1].valid && c[1].dest == r)
            res = c[1].value;
        return res;
    endfunction

    function automatic logic [31:0] aluResult(
        input aluOp_e op,
        input logic [31:0] a,
        input logic [31:0] b
    );
        case (op)
            aluAdd: return a + b;
            aluSub: return a - b;
            aluAnd: return a & b;
            aluOr: return a | b;
            aluXor: return a ^ b;
            aluSlt: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluLui: return b;
            aluMul: return a * b; // low word of the product.
            default: return '0;
        endcase
    endfunction

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            fwdA[i] = forward(execIn[i].rs, execIn[i].valA, commit);
            fwdB[i] = forward(execIn[i].rt, execIn[i].valB, commit);
        end
        // writeback drains during a mul stall, so use the captured operands.
        opA = firstCycle ? fwdA : savedA;
        opB = firstCycle ? fwdB : savedB;
        result[0] = aluResult(execIn[0].op, opA[0],
                              execIn[0].useImm ? execIn[0].imm : opB[0]);
        // cascade slot 0 result into slot 1.
        if (execIn[0].valid && execIn[0].writes && execIn[0].dest == execIn[1].rs)
            opA[1] = result[0];
        if (execIn[0].valid && execIn[0].writes && execIn[0].dest == execIn[1].rt)
            opB[1] = result[0];
        result[1] = aluResult(execIn[1].op, opA[1],
                              execIn[1].useImm ? execIn[1].imm : opB[1]);
        for (int i = 0; i < 2; i++)
        begin
            target[i] = execIn[i].pc + 32'd4 + {execIn[i].imm[29:0], 2'b00};
            taken[i] = execIn[i].valid
                && ((execIn[i].op == aluBeq && opA[i] == opB[i])
                    || (execIn[i].op == aluBne && opA[i] != opB[i]));
        end
    end

    assign hasMul = (execIn[0].valid && execIn[0].op == aluMul)
        || (execIn[1].valid && execIn[1].op == aluMul);
    assign cyclesDone = firstCycle ? '0 : mulCount;
    assign busy = hasMul && (cyclesDone < mulCountWidth'(mulLatency - 1));

    // redirect waits for the pair to finish so the flush cannot kill it.
    assign redirect = !busy && (taken[0] || taken[1]);
    assign redirectPc = taken[0] ? target[0] : target[1];

    always_comb
    begin
        for (int i = 0; i < 2; i++)
        begin
            commitNext[i].valid = execIn[i].valid && execIn[i].writes && !busy;
            commitNext[i].dest = execIn[i].dest;
            commitNext[i].value = result[i];
        end
        commitNext[1].valid = commitNext[1].valid && !taken[0];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            commit <= '0;
            mulCount <= '0;
        end
        else
        begin
            commit <= commitNext;
            mulCount <= busy ? cyclesDone + 1'b1 : '0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (firstCycle)
        begin
            savedA <= fwdA;
            savedB <= fwdB;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetchStage.sv
`default_nettype none

module fetchStage
    import mipsPkg::*;
(
    input logic clk,
    input logic reset,
    input logic stall,
    input logic redirect,
    input logic [31:0] redirectPc,
    input logic imemReady,
    input logic [1:0][31:0] imemData,
    output logic [31:0] imemAddr,
    output fetchPair_t fetchOut
);

    logic [31:0] pc;

    assign imemAddr = pc;

    always_ff @(posedge clk)
    begin
        if (reset)
            pc <= resetPc;
        else if (redirect)
            pc <= redirectPc; // taken branch wins over stall.
        else if (imemReady && !stall)
            pc <= pc + 32'd8;
    end

    // both slots share the ready level; no ready means a bubble pair.
    always_comb
    begin
        fetchOut[0].valid = imemReady;
        fetchOut[0].pc = pc;
        fetchOut[0].instr = imemData[0];
        fetchOut[1].valid = imemReady;
        fetchOut[1].pc = pc + 32'd4;
        fetchOut[1].instr = imemData[1];
    end

endmodule

`default_nettype wire

//--- rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

    localparam logic [31:0] resetPc = 32'h0000_0000;
    localparam int mulLatency = 4;
    localparam int mulCountWidth = $clog2(mulLatency + 1);

    // primary opcodes.
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opSpecial2 = 6'h1c;
    localparam logic [5:0] opBeq = 6'h04;
    localparam logic [5:0] opBne = 6'h05;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opOri = 6'h0d;
    localparam logic [5:0] opLui = 6'h0f;

    // function field values.
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr = 6'h25;
    localparam logic [5:0] fnXor = 6'h26;
    localparam logic [5:0] fnSlt = 6'h2a;
    localparam logic [5:0] fnMul = 6'h02; // special2 group.

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } fetchSlot_t;

    typedef fetchSlot_t [1:0] fetchPair_t; // slot 0 is older.

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluLui, aluMul, aluBeq, aluBne, aluNop
    } aluOp_e;

    typedef struct packed {
        logic valid;
        aluOp_e op;
        logic writes;
        logic [4:0] dest;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [31:0] valA;
        logic [31:0] valB;
        logic [31:0] imm;
        logic useImm;
        logic [31:0] pc;
    } execSlot_t;

    typedef execSlot_t [1:0] execPair_t;

    typedef struct packed {
        logic valid;
        logic [4:0] dest;
        logic [31:0] value;
    } commitSlot_t;

    typedef commitSlot_t [1:0] commitPair_t;

endpackage

`default_nettype wire

//--- rtl/pipeReg.sv
`default_nettype none

module pipeReg
#(
    parameter type payloadType = logic
)
(
    input logic clk,
    input logic reset,
    input logic stall,
    input logic flush,
    input payloadType din,
    output payloadType dout,
    output logic firstCycle
);

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            dout <= '0;
            firstCycle <= 1'b1;
        end
        else if (!stall)
        begin
            dout <= din;
            firstCycle <= 1'b1;
        end
        else
        begin
            // contents held, so the consumer has already seen them.
            firstCycle <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`default_nettype none

module regFile
    import mipsPkg::*;
(
    input logic clk,
    input logic [3:0][4:0] readAddr,
    output logic [3:0][31:0] readData,
    input commitPair_t writes
);

    logic [31:0] regs [32];

    // slot 1 is written last, so it wins on a shared destination.
    always_ff @(posedge clk)
    begin
        if (writes[0].valid && writes[0].dest != 5'd0)
            regs[writes[0].dest] <= writes[0].value;
        if (writes[1].valid && writes[1].dest != 5'd0)
            regs[writes[1].dest] <= writes[1].value;
    end

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (readAddr[i] == 5'd0)
                readData[i] = '0;
            else if (writes[1].valid && writes[1].dest == readAddr[i])
                readData[i] = writes[1].value; // write-first bypass.
            else if (writes[0].valid && writes[0].dest == readAddr[i])
                readData[i] = writes[0].value;
            else
                readData[i] = regs[readAddr[i]];
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the dual-issue core testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sources.f --top-module coreTb -Mdir obj_dir

./obj_dir/VcoreTb > sim.log 2>&1
cat sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
else
    echo "run.sh: simulation failed, see sim.log"
    exit 1
fi

//--- sim/corePatterns.txt
// program: word count, then instruction words, one pair per line (slot 0, slot 1)
// commits: count, then one line per commit with dest register and value, in program order
00000022
3c011234 24020005
34215678 2443fffd
00232021 00822823
00223026 0062382a
00a64024 24400007
00074825 240affff
71466002 01876821
70427002 0180782a
01cd8021 10e90002
24140111 24150222
14620003 24160333
24170444 24180555
10430005 15270005
26110001 10000001
24190666 2632ffef
02529821 24000055
00001025 00531821
00000015
01 12340000
02 00000005
01 12345678
03 00000002
04 1234567a
05 12345675
06 1234567d
07 00000001
08 12345675
09 00000001
0a ffffffff
0c edcba983
0d edcba984
0e 00000019
0f 00000001
10 edcba99d
11 edcba99e
12 edcba98d
13 db97531a
02 00000000
03 db97531a

//--- sim/coreTb.sv
`default_nettype none

module coreTb
    import mipsPkg::*;
();

    logic clk;
    logic reset;
    logic imemReady;
    logic [1:0][31:0] imemData;
    logic [31:0] imemAddr;
    commitPair_t commit;

    logic [31:0] patterns [0:255];
    logic [31:0] imem [$];
    logic [31:0] expDest [$];
    logic [31:0] expValue [$];
    logic memLoaded;
    logic [31:0] rngState;
    int errorCount;
    int commitIndex;

    dualIssueCore dut (
        .clk(clk),
        .reset(reset),
        .imemReady(imemReady),
        .imemData(imemData),
        .imemAddr(imemAddr),
        .commit(commit)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] fetchWord(input logic [31:0] addr);
        int wordIndex;
        wordIndex = int'(addr >> 2);
        if (wordIndex >= imem.size())
            return 32'd0; // sll $0, $0, 0 is the nop.
        return imem[wordIndex];
    endfunction

    function automatic logic [31:0] patternAt(input int k);
        return patterns[8'(k)];
    endfunction

    // memory answers in the same cycle.
    always @*
    begin
        imemData[0] = memLoaded ? fetchWord(imemAddr) : 32'd0;
        imemData[1] = memLoaded ? fetchWord(imemAddr + 32'd4) : 32'd0;
    end

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
        if (got !== expected)
        begin
            errorCount++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic takeCommit(input commitSlot_t slot);
        if (commitIndex >= expValue.size())
        begin
            errorCount++;
            $display("unexpected commit to register %0d after the expected stream ended",
                     slot.dest);
        end
        else
        begin
            checkValue($sformatf("commit %0d dest", commitIndex), 32'(slot.dest),
                       expDest[commitIndex]);
            checkValue($sformatf("commit %0d value", commitIndex), slot.value,
                       expValue[commitIndex]);
        end
        commitIndex++;
    endtask

    // layout is program count, words, commit count, then dest and value pairs.
    task automatic loadPatterns();
        int progCount;
        int expCount;
        int base;
        $readmemh("sim/corePatterns.txt", patterns);
        progCount = int'(patterns[0]);
        if (progCount <= 0 || progCount > 200)
        begin
            errorCount++;
            $display("pattern file sim/corePatterns.txt is missing or has a bad program count");
            return;
        end
        for (int k = 0; k < progCount; k++)
            imem.push_back(patternAt(k + 1));
        expCount = int'(patternAt(progCount + 1));
        base = progCount + 2;
        if (expCount <= 0 || base + 2 * expCount > 256)
        begin
            errorCount++;
            $display("pattern file sim/corePatterns.txt has a bad commit count");
            return;
        end
        for (int k = 0; k < expCount; k++)
        begin
            expDest.push_back(patternAt(base + 2 * k));
            expValue.push_back(patternAt(base + 2 * k + 1));
        end
    endtask

    always @(posedge clk)
    begin
        #1;
        rngState = xorshift(rngState);
        imemReady = rngState[1:0] != 2'b00; // ready about three quarters of the time.
    end

    // slot 0 is older, so it is taken first.
    always @(posedge clk)
    begin
        if (!reset)
        begin
            if (commit[0].valid)
                takeCommit(commit[0]);
            if (commit[1].valid)
                takeCommit(commit[1]);
        end
    end

    initial
    begin
        int cycles;
        reset = 1'b1;
        imemReady = 1'b0;
        memLoaded = 1'b0;
        rngState = 32'h13ff_9c82;
        errorCount = 0;
        commitIndex = 0;
        loadPatterns();
        memLoaded = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        cycles = 0;
        while (commitIndex < expValue.size() && cycles < 2000)
        begin
            @(negedge clk);
            cycles++;
        end
        if (commitIndex < expValue.size())
        begin
            errorCount++;
            $display("timeout after %0d cycles: only %0d of %0d commits arrived",
                     cycles, commitIndex, expValue.size());
        end
        repeat (20) @(negedge clk); // stray commits after the stream show up here.
        $display("errors: %0d, commits seen: %0d of %0d",
                 errorCount, commitIndex, expValue.size());
        if (errorCount == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
rtl/mipsPkg.sv
rtl/fetchStage.sv
rtl/pipeReg.sv
rtl/regFile.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/dualIssueCore.sv
sim/coreTb.sv
